/* verilog/vic_timing_pkg.sv */
`default_nettype none

package vic_timing_pkg;

    // chip model code as written to the config register
    typedef logic [1:0] chip_t;

    // pixel position inside one raster line
    typedef logic [9:0] raster_x_t;

    // raster line number inside one frame
    typedef logic [8:0] raster_y_t;

    // reset hold counter, must reach RESET_HOLD_CYCLES
    typedef logic [6:0] hold_count_t;

    // supported chip models, code 3 (6572) is not modelled
    localparam chip_t CHIP6567R8   = 2'd0;
    localparam chip_t CHIP6569     = 2'd1;
    localparam chip_t CHIP6567R56A = 2'd2;
    localparam chip_t CHIP_DEFAULT = CHIP6569;

    // shortened power-on hold so simulation stays quick
    localparam int RESET_HOLD_CYCLES = 64;

    // sys_clock runs at 4x the dot rate
    localparam int DOT_PHASES     = 4;
    localparam int DOTS_PER_CYCLE = 8;

    // raster geometry per model
    localparam int LINE_PIXELS_R8   = 520;
    localparam int FRAME_LINES_R8   = 263;
    localparam int LINE_PIXELS_PAL  = 504;
    localparam int FRAME_LINES_PAL  = 312;
    localparam int LINE_PIXELS_R56A = 512;
    localparam int FRAME_LINES_R56A = 262;

    // sync windows, shared by all models
    localparam int HSYNC_START  = 416;
    localparam int HSYNC_PIXELS = 40;
    localparam int VSYNC_LINES  = 3;

    // reset sequencer states
    typedef enum logic [1:0] {
        HOLD,
        SYNC,
        RUN
    } seq_state_t;

endpackage

`default_nettype wire

/* verilog/chip_config.sv */
`timescale 1ns/1ns
`default_nettype none

module chip_config (
    input  logic                  sys_clock,
    input  logic                  internal_rst,
    input  logic                  cfg_write,
    input  vic_timing_pkg::chip_t cfg_chip,
    output vic_timing_pkg::chip_t chip,
    output logic                  chip_changed,
    output logic                  cfg_reject
);

    import vic_timing_pkg::*;

    // codes above the last modelled chip are refused
    logic code_valid;

    assign code_valid = (cfg_chip <= CHIP6567R56A);

    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            chip         <= CHIP_DEFAULT;
            chip_changed <= 1'b0;
            cfg_reject   <= 1'b0;
        end else begin
            // both flags are single-cycle pulses
            chip_changed <= 1'b0;
            cfg_reject   <= 1'b0;
            if (cfg_write) begin
                if (code_valid) begin
                    chip <= cfg_chip;
                    // rewriting the same model must not restart timing
                    chip_changed <= (cfg_chip != chip);
                end else begin
                    // keep the old model, just flag the bad write
                    cfg_reject <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/reset_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module reset_sequencer (
    input  logic sys_clock,
    input  logic internal_rst,
    input  logic chip_changed,
    output logic video_rst
);

    import vic_timing_pkg::*;

    seq_state_t  state;
    hold_count_t hold_count;

    // two-stage release chain, bit 1 is the synchronized release
    logic [1:0] release_q;

    always_ff @(posedge sys_clock) begin
        if (internal_rst || chip_changed) begin
            // a model change restarts exactly like power-on
            state      <= HOLD;
            hold_count <= '0;
            release_q  <= 2'b00;
        end else begin
            case (state)
                HOLD: begin
                    hold_count <= hold_count + 1'b1;
                    // last hold cycle, hand over to the sync stages
                    if (hold_count == hold_count_t'(RESET_HOLD_CYCLES - 1)) begin
                        state <= SYNC;
                    end
                end
                SYNC: begin
                    release_q <= {release_q[0], 1'b1};
                    // second stage loads on this edge
                    if (release_q[0]) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    // release stays set until the next restart
                    release_q <= 2'b11;
                end
                default: begin
                    state <= HOLD;
                end
            endcase
        end
    end

    // core reset is held until the release reaches the second stage
    assign video_rst = ~release_q[1];

endmodule

`default_nettype wire

/* verilog/dot_phase_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module dot_phase_gen (
    input  logic sys_clock,
    input  logic video_rst,
    output logic dot_ce,
    output logic cycle_ce
);

    import vic_timing_pkg::*;

    // position within one dot, four sys_clock cycles
    logic [1:0] phase;

    // dot index within one cpu cycle
    logic [2:0] dot_count;

    always_ff @(posedge sys_clock) begin
        if (video_rst) begin
            phase     <= 2'd0;
            dot_count <= 3'd0;
        end else begin
            phase <= phase + 2'd1;
            // dot counter steps once per completed dot
            if (dot_ce) begin
                dot_count <= dot_count + 3'd1;
            end
        end
    end

    // last phase of each dot, so the first dot lands on the 4th cycle
    assign dot_ce = (phase == 2'(DOT_PHASES - 1));

    // cpu cycle boundary on every 8th dot
    assign cycle_ce = dot_ce && (dot_count == 3'(DOTS_PER_CYCLE - 1));

endmodule

`default_nettype wire

/* verilog/raster_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module raster_timer (
    input  logic                      sys_clock,
    input  logic                      video_rst,
    input  vic_timing_pkg::chip_t     chip,
    input  logic                      dot_ce,
    input  logic                      cycle_ce,
    output vic_timing_pkg::raster_x_t raster_x,
    output vic_timing_pkg::raster_y_t raster_y,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      frame_start
);

    import vic_timing_pkg::*;

    // last pixel and last line of the selected model
    raster_x_t line_last;
    raster_y_t frame_last;

    // previous model, used to spot a change before video_rst arrives
    chip_t chip_q;
    logic  chip_moved;
    logic  clear;

    logic line_end;
    logic frame_end;

    always_comb begin
        case (chip)
            CHIP6567R8: begin
                line_last  = raster_x_t'(LINE_PIXELS_R8 - 1);
                frame_last = raster_y_t'(FRAME_LINES_R8 - 1);
            end
            CHIP6567R56A: begin
                line_last  = raster_x_t'(LINE_PIXELS_R56A - 1);
                frame_last = raster_y_t'(FRAME_LINES_R56A - 1);
            end
            default: begin
                // 6569 pal, also covers the unused code
                line_last  = raster_x_t'(LINE_PIXELS_PAL - 1);
                frame_last = raster_y_t'(FRAME_LINES_PAL - 1);
            end
        endcase
    end

    // model switches one edge before video_rst rises
    // chip_moved keeps the syncs quiet across that cycle
    assign chip_moved = (chip != chip_q);
    assign clear      = video_rst || chip_moved;

    always_ff @(posedge sys_clock) begin
        chip_q <= chip;
    end

    // lines may only end on a cpu cycle boundary
    assign line_end    = cycle_ce && (raster_x >= line_last);
    assign frame_end   = (raster_y >= frame_last);
    assign frame_start = dot_ce && line_end && frame_end;

    always_ff @(posedge sys_clock) begin
        if (clear) begin
            raster_x <= '0;
            raster_y <= '0;
            hsync    <= 1'b0;
            vsync    <= 1'b0;
        end else begin
            // syncs follow the counters one cycle later
            hsync <= (raster_x >= raster_x_t'(HSYNC_START)) &&
                     (raster_x < raster_x_t'(HSYNC_START + HSYNC_PIXELS));
            vsync <= (raster_y < raster_y_t'(VSYNC_LINES));
            if (dot_ce) begin
                if (cycle_ce) begin
                    if (line_end) begin
                        raster_x <= '0;
                        if (frame_end) begin
                            raster_y <= '0;
                        end else begin
                            raster_y <= raster_y + 1'b1;
                        end
                    end else begin
                        // snap to the next cycle start, plain +1 when aligned
                        raster_x <= {raster_x[9:3] + 7'd1, 3'b000};
                    end
                end else begin
                    raster_x <= raster_x + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/vic_timing_top.sv */
`timescale 1ns/1ns
`default_nettype none

module vic_timing_top (
    input  logic                      sys_clock,
    input  logic                      internal_rst,
    input  logic                      cfg_write,
    input  vic_timing_pkg::chip_t     cfg_chip,
    output vic_timing_pkg::chip_t     chip,
    output logic                      cfg_reject,
    output logic                      video_rst,
    output logic                      dot_ce,
    output vic_timing_pkg::raster_x_t raster_x,
    output vic_timing_pkg::raster_y_t raster_y,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      frame_start
);

    // restart request from the config register
    logic chip_changed;

    // cpu cycle boundary, only used by the raster counters
    logic cycle_ce;

    chip_config chip_config_i (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .cfg_write    (cfg_write),
        .cfg_chip     (cfg_chip),
        .chip         (chip),
        .chip_changed (chip_changed),
        .cfg_reject   (cfg_reject)
    );

    reset_sequencer reset_sequencer_i (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .chip_changed (chip_changed),
        .video_rst    (video_rst)
    );

    dot_phase_gen dot_phase_gen_i (
        .sys_clock (sys_clock),
        .video_rst (video_rst),
        .dot_ce    (dot_ce),
        .cycle_ce  (cycle_ce)
    );

    raster_timer raster_timer_i (
        .sys_clock   (sys_clock),
        .video_rst   (video_rst),
        .chip        (chip),
        .dot_ce      (dot_ce),
        .cycle_ce    (cycle_ce),
        .raster_x    (raster_x),
        .raster_y    (raster_y),
        .hsync       (hsync),
        .vsync       (vsync),
        .frame_start (frame_start)
    );

endmodule

`default_nettype wire

/* bench/vic_timing_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module vic_timing_sva (
    input logic                  sys_clock,
    input logic                  internal_rst,
    input logic                  video_rst,
    input logic                  dot_ce,
    input logic                  hsync,
    input logic                  vsync,
    input logic                  cfg_reject,
    input vic_timing_pkg::chip_t chip
);

    // one dot every four clocks, never back to back
    dot_ce_single: assert property (@(posedge sys_clock) disable iff (internal_rst)
        dot_ce |=> !dot_ce)
        else $error("dot_ce high in two consecutive cycles");

    // no sync output while the core is held in reset
    sync_quiet_in_reset: assert property (@(posedge sys_clock) disable iff (internal_rst)
        video_rst |-> (!hsync && !vsync))
        else $error("sync active while video_rst is high");

    // a refused code keeps the old model
    reject_keeps_chip: assert property (@(posedge sys_clock) disable iff (internal_rst)
        cfg_reject |-> $stable(chip))
        else $error("chip changed together with cfg_reject");

endmodule

bind vic_timing_top vic_timing_sva vic_timing_sva_i (
    .sys_clock    (sys_clock),
    .internal_rst (internal_rst),
    .video_rst    (video_rst),
    .dot_ce       (dot_ce),
    .hsync        (hsync),
    .vsync        (vsync),
    .cfg_reject   (cfg_reject),
    .chip         (chip)
);

`default_nettype wire

/* bench/vic_timing_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module vic_timing_tb;

    import vic_timing_pkg::*;

    // bound for every wait loop, well above two frames of the longest model
    localparam int WAIT_LIMIT   = 2_000_000;
    localparam int RESET_LEN    = RESET_HOLD_CYCLES + 2;
    localparam int QUIET_CYCLES = 100;
    localparam int RANDOM_WRITES = 6;

    logic      sys_clock;
    logic      internal_rst;
    logic      cfg_write;
    chip_t     cfg_chip;
    chip_t     chip;
    logic      cfg_reject;
    logic      video_rst;
    logic      dot_ce;
    raster_x_t raster_x;
    raster_y_t raster_y;
    logic      hsync;
    logic      vsync;
    logic      frame_start;

    int   errors;
    int   tests_run;
    int   tests_failed;
    int   test_start;
    int   seed;
    logic timed_out;

    vic_timing_top vic_timing_top_i (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .cfg_write    (cfg_write),
        .cfg_chip     (cfg_chip),
        .chip         (chip),
        .cfg_reject   (cfg_reject),
        .video_rst    (video_rst),
        .dot_ce       (dot_ce),
        .raster_x     (raster_x),
        .raster_y     (raster_y),
        .hsync        (hsync),
        .vsync        (vsync),
        .frame_start  (frame_start)
    );

    // 100 ns period
    initial sys_clock = 1'b0;
    always #50 sys_clock = ~sys_clock;

    // expected geometry straight from the model table
    function automatic int ref_line_pixels(input chip_t code);
        case (code)
            CHIP6567R8:   return 520;
            CHIP6567R56A: return 512;
            default:      return 504;
        endcase
    endfunction

    function automatic int ref_frame_lines(input chip_t code);
        case (code)
            CHIP6567R8:   return 263;
            CHIP6567R56A: return 262;
            default:      return 312;
        endcase
    endfunction

    // sync windows shared by all models
    function automatic logic ref_hsync(input int x);
        return (x >= 416) && (x < 416 + 40);
    endfunction

    function automatic logic ref_vsync(input int y);
        return (y < 3);
    endfunction

    // compare syncs at every dot against the counters of that dot
    always @(negedge sys_clock) begin
        if (!video_rst && dot_ce) begin
            if (hsync !== ref_hsync(raster_x)) begin
                $display("Fail hsync: got %h expected %h at raster_x %h",
                         hsync, ref_hsync(raster_x), raster_x);
                errors++;
            end
            if (vsync !== ref_vsync(raster_y)) begin
                $display("Fail vsync: got %h expected %h at raster_y %h",
                         vsync, ref_vsync(raster_y), raster_y);
                errors++;
            end
        end
    end

    task automatic flag_timeout(input string what);
        $display("Timeout: %s", what);
        timed_out = 1'b1;
        errors++;
    endtask

    // one line per finished test
    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_start) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_start);
        end else begin
            $display("test %s: ok", name);
        end
        test_start = errors;
    endtask

    // called on a falling edge, the write is taken at the next rising edge
    task automatic write_chip(input chip_t code);
        cfg_chip  = code;
        cfg_write = 1'b1;
        @(negedge sys_clock);
        cfg_write = 1'b0;
    endtask

    // counts rising edges until video_rst drops, starting with video_rst high
    task automatic count_reset_cycles(output int len);
        len = 0;
        while (video_rst && len < WAIT_LIMIT) begin
            @(negedge sys_clock);
            len++;
        end
        if (video_rst) begin
            flag_timeout("video_rst was never released");
        end
    endtask

    // a real model change must restart the reset sequence
    task automatic check_restart(input chip_t code);
        int n;
        int len;
        n = 0;
        write_chip(code);
        while (!video_rst && n < 10) begin
            @(negedge sys_clock);
            n++;
        end
        if (!video_rst) begin
            flag_timeout("video_rst did not rise after a model change");
        end else begin
            count_reset_cycles(len);
            if (len != RESET_LEN) begin
                $display("Fail video_rst length: got %h expected %h", len, RESET_LEN);
                errors++;
            end
        end
        if (chip != code) begin
            $display("Fail chip: got %h expected %h", chip, code);
            errors++;
        end
    endtask

    // after a write that must not restart, watch reset, model and reject pulses
    task automatic observe_quiet(input chip_t expect_chip, input int expect_rejects);
        int    rejects;
        logic  rst_seen;
        logic  chip_bad;
        chip_t bad_chip;
        rejects  = 0;
        rst_seen = 1'b0;
        chip_bad = 1'b0;
        bad_chip = expect_chip;
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            if (cfg_reject) begin
                rejects++;
            end
            if (video_rst) begin
                rst_seen = 1'b1;
            end
            if (chip != expect_chip && !chip_bad) begin
                chip_bad = 1'b1;
                bad_chip = chip;
            end
            @(negedge sys_clock);
        end
        if (rst_seen) begin
            $display("video_rst rose although the model did not change");
            errors++;
        end
        if (chip_bad) begin
            $display("Fail chip: got %h expected %h", bad_chip, expect_chip);
            errors++;
        end
        if (rejects != expect_rejects) begin
            $display("Fail cfg_reject pulses: got %h expected %h", rejects, expect_rejects);
            errors++;
        end
    endtask

    // skip to one frame_start, then measure the whole next frame
    task automatic measure_frame(input chip_t code);
        int n;
        int dots;
        int max_x;
        int max_y;
        n     = 0;
        dots  = 0;
        max_x = 0;
        max_y = 0;
        while (!frame_start && n < WAIT_LIMIT) begin
            @(negedge sys_clock);
            n++;
        end
        if (!frame_start) begin
            flag_timeout("no first frame_start");
        end else begin
            n = 0;
            do begin
                @(negedge sys_clock);
                n++;
                if (dot_ce) begin
                    dots++;
                    if (int'(raster_x) > max_x) begin
                        max_x = raster_x;
                    end
                    if (int'(raster_y) > max_y) begin
                        max_y = raster_y;
                    end
                end
            end while (!frame_start && n < WAIT_LIMIT);
            if (!frame_start) begin
                flag_timeout("no second frame_start");
            end else begin
                if (dots != ref_line_pixels(code) * ref_frame_lines(code)) begin
                    $display("Fail dot_ce per frame: got %h expected %h",
                             dots, ref_line_pixels(code) * ref_frame_lines(code));
                    errors++;
                end
                if (max_x + 1 != ref_line_pixels(code)) begin
                    $display("Fail raster_x max: got %h expected %h",
                             max_x, ref_line_pixels(code) - 1);
                    errors++;
                end
                if (max_y + 1 != ref_frame_lines(code)) begin
                    $display("Fail raster_y max: got %h expected %h",
                             max_y, ref_frame_lines(code) - 1);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        chip_t code;
        int    len;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_start   = 0;
        timed_out    = 1'b0;
        seed         = 32'h7f61;
        internal_rst = 1'b1;
        cfg_write    = 1'b0;
        cfg_chip     = CHIP_DEFAULT;
        repeat (10) @(negedge sys_clock);
        internal_rst = 1'b0;

        // power-on hold and default model
        count_reset_cycles(len);
        if (len != RESET_LEN) begin
            $display("Fail video_rst length: got %h expected %h", len, RESET_LEN);
            errors++;
        end
        if (chip != CHIP6569) begin
            $display("Fail chip: got %h expected %h", chip, CHIP6569);
            errors++;
        end
        end_test("power-on reset");

        if (!timed_out) begin
            measure_frame(CHIP6569);
        end
        end_test("default frame");

        // every model once, each differing from the one before
        if (!timed_out) begin
            check_restart(CHIP6567R8);
            measure_frame(CHIP6567R8);
            check_restart(CHIP6567R56A);
            measure_frame(CHIP6567R56A);
            check_restart(CHIP6569);
            measure_frame(CHIP6569);
        end
        end_test("model switch");

        // 6572 code is refused, same model rewrite is ignored
        if (!timed_out) begin
            write_chip(2'd3);
            observe_quiet(CHIP6569, 1);
            write_chip(CHIP6569);
            observe_quiet(CHIP6569, 0);
        end
        end_test("rejected and repeated writes");

        // random valid models mixed with rejected writes, syncs checked throughout
        for (int i = 0; i < RANDOM_WRITES && !timed_out; i++) begin
            code = chip_t'($unsigned($random(seed)) % 3);
            if (code == chip) begin
                write_chip(code);
                observe_quiet(code, 0);
            end else begin
                check_restart(code);
            end
            repeat (3000) @(negedge sys_clock);
            write_chip(2'd3);
            observe_quiet(code, 1);
        end
        end_test("random model writes");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
verilog/vic_timing_pkg.sv
verilog/chip_config.sv
verilog/reset_sequencer.sv
verilog/dot_phase_gen.sv
verilog/raster_timer.sv
verilog/vic_timing_top.sv
bench/vic_timing_sva.sv
bench/vic_timing_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the vic timing testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module vic_timing_tb \
    -f files.f \
    -o vic_timing_sim

./obj_dir/vic_timing_sim | tee "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failure"
